// ==== all.f ====
img_pkg.sv
fletcher_checksum.sv
frame_decoder.sv
pixel_store.sv
readout_sequencer.sv
img_controller.sv
tb_img_controller.sv

// ==== fletcher_checksum.sv ====
`timescale 1ns/1ns

module fletcher_checksum import img_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   clear,
    input  logic                   en,
    input  pixel_word_t            din,
    output logic [2*WORD_BITS-1:0] sum
);

    logic [WORD_BITS-1:0] a;
    logic [WORD_BITS-1:0] b;
    logic [WORD_BITS-1:0] a_next;

    // Sum modulo 2^16-1, a single subtract covers the whole range
    function automatic logic [WORD_BITS-1:0] add_mod(
        input logic [WORD_BITS-1:0] lhs,
        input logic [WORD_BITS-1:0] rhs
    );
        logic [WORD_BITS:0] s;
        s = {1'b0, lhs} + {1'b0, rhs};
        if (s >= {1'b0, {WORD_BITS{1'b1}}}) begin
            s = s - {1'b0, {WORD_BITS{1'b1}}};
        end
        return s[WORD_BITS-1:0];
    endfunction

    assign a_next = add_mod(a, din);
    assign sum    = {b, a};

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            a <= '0;
            b <= '0;
        end else if (en) begin
            a <= a_next;
            b <= add_mod(b, a_next);
        end
    end

endmodule

// ==== frame_decoder.sv ====
`timescale 1ns/1ns

module frame_decoder import img_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_capture,
    input  logic [SKIP_BITS-1:0]  cmd_skip_count,
    input  logic [PIXEL_BITS-1:0] img_pixel,
    input  logic                  img_fv,
    input  logic                  img_lv,
    output pixel_wr_t             pix_wr,
    output capture_stats_t        status_stats,
    output logic                  status_capture_done
);

    enum logic [2:0] {
        ST_IDLE,
        ST_ARM,
        ST_WAIT_FRAME,
        ST_SKIP_CHECK,
        ST_CAPTURE
    } state;

    logic                 capture_prev;
    logic                 capture_cmd;
    logic                 fv_prev;
    logic                 lv_prev;
    logic                 frame_start;
    logic [1:0]           x;
    logic [1:0]           y;
    logic [SKIP_BITS-1:0] skip_count;
    logic [ADDR_BITS-1:0] wr_addr;
    logic                 stat_point;
    logic [6:0]           px_top;

    assign capture_cmd = cmd_capture ^ capture_prev;
    assign frame_start = img_fv && !fv_prev;

    // One sample per 4x4 block
    assign stat_point = img_lv && (x == 2'd0) && (y == 2'd0);
    assign px_top     = img_pixel[PIXEL_BITS-1 -: 7];

    // ==========================================================
    // Capture FSM, position tracking and statistics
    // ==========================================================
    always_ff @(posedge clk) begin
        // Low byte goes out first on the wire
        pix_wr.data <= {img_pixel[7:0], 4'b0000, img_pixel[PIXEL_BITS-1:8]};
        pix_wr.addr <= wr_addr;

        if (rst) begin
            state               <= ST_IDLE;
            capture_prev        <= 1'b0;
            fv_prev             <= 1'b0;
            lv_prev             <= 1'b0;
            x                   <= '0;
            y                   <= '0;
            skip_count          <= '0;
            wr_addr             <= '0;
            pix_wr.en           <= 1'b0;
            status_stats        <= '0;
            status_capture_done <= 1'b0;
        end else begin
            capture_prev <= cmd_capture;
            fv_prev      <= img_fv;
            lv_prev      <= img_lv;
            pix_wr.en    <= 1'b0;

            if (!img_lv) begin
                x <= '0;
            end else begin
                x <= x + 1'b1;
            end

            // Row advances at the end of each line
            if (!img_fv) begin
                y <= '0;
            end else if (lv_prev && !img_lv) begin
                y <= y + 1'b1;
            end

            if (pix_wr.en) begin
                status_stats.pixel_count <= status_stats.pixel_count + 1'b1;
            end

            case (state)
                ST_ARM: begin
                    status_stats <= '0;
                    skip_count   <= cmd_skip_count;
                    wr_addr      <= '0;
                    state        <= ST_WAIT_FRAME;
                end
                ST_WAIT_FRAME: begin
                    if (frame_start) begin
                        state <= ST_SKIP_CHECK;
                    end
                end
                ST_SKIP_CHECK: begin
                    if (skip_count != '0) begin
                        skip_count <= skip_count - 1'b1;
                        state      <= ST_WAIT_FRAME;
                    end else begin
                        state <= ST_CAPTURE;
                    end
                end
                ST_CAPTURE: begin
                    if (img_fv) begin
                        pix_wr.en <= img_lv;
                        if (img_lv) begin
                            wr_addr <= wr_addr + 1'b1;
                        end
                        if (stat_point && (px_top == 7'h7f)) begin
                            status_stats.highlight_count <=
                                status_stats.highlight_count + 1'b1;
                        end
                        if (stat_point && (px_top == 7'h00)) begin
                            status_stats.shadow_count <= status_stats.shadow_count + 1'b1;
                        end
                    end else begin
                        // Frame end
                        status_capture_done <= !status_capture_done;
                        state               <= ST_IDLE;
                    end
                end
                default: begin
                end
            endcase

            // A new command restarts from any state
            if (capture_cmd) begin
                state <= ST_ARM;
            end
        end
    end

    // Writes fill the store in order and never run past the frame
    assert property (@(posedge clk) disable iff (rst)
        pix_wr.en |-> (pix_wr.addr == status_stats.pixel_count[ADDR_BITS-1:0])
                      && (status_stats.pixel_count < COUNT_BITS'(IMG_PIXELS)));

endmodule

// ==== img_controller.sv ====
`timescale 1ns/1ns

module img_controller import img_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,

    // Commands
    input  logic                  cmd_capture,
    input  logic                  cmd_readout,
    input  logic [SKIP_BITS-1:0]  cmd_skip_count,
    input  header_t               cmd_header,

    // Sensor
    input  logic [PIXEL_BITS-1:0] img_pixel,
    input  logic                  img_fv,
    input  logic                  img_lv,

    // Status
    output logic                  status_capture_done,
    output capture_stats_t        status_stats,

    // Readout stream
    output logic                  readout_start,
    output logic                  readout_ready,
    input  logic                  readout_trigger,
    output pixel_word_t           readout_data
);

    pixel_wr_t            pix_wr;
    logic [ADDR_BITS-1:0] rd_addr;
    pixel_word_t          rd_data;

    // ==========================================================
    // Capture side
    // ==========================================================
    frame_decoder frame_decoder_i (
        .clk                 (clk),
        .rst                 (rst),
        .cmd_capture         (cmd_capture),
        .cmd_skip_count      (cmd_skip_count),
        .img_pixel           (img_pixel),
        .img_fv              (img_fv),
        .img_lv              (img_lv),
        .pix_wr              (pix_wr),
        .status_stats        (status_stats),
        .status_capture_done (status_capture_done)
    );

    pixel_store pixel_store_i (
        .clk     (clk),
        .pix_wr  (pix_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // ==========================================================
    // Readout side
    // ==========================================================
    readout_sequencer readout_sequencer_i (
        .clk             (clk),
        .rst             (rst),
        .cmd_readout     (cmd_readout),
        .cmd_header      (cmd_header),
        .rd_addr         (rd_addr),
        .rd_data         (rd_data),
        .readout_start   (readout_start),
        .readout_ready   (readout_ready),
        .readout_trigger (readout_trigger),
        .readout_data    (readout_data)
    );

endmodule

// ==== img_pkg.sv ====
package img_pkg;

    // ==========================================================
    // Frame geometry and word widths
    // ==========================================================
    localparam int IMG_WIDTH  = 8;
    localparam int IMG_HEIGHT = 8;
    localparam int IMG_PIXELS = IMG_WIDTH * IMG_HEIGHT;

    localparam int PIXEL_BITS = 12;
    localparam int WORD_BITS  = 16;

    // Readout framing
    localparam int HEADER_WORDS   = 4;
    localparam int CHECKSUM_WORDS = 2;
    localparam int PADDING_WORDS  = 2;

    localparam int STAT_BITS  = 18;
    localparam int ADDR_BITS  = $clog2(IMG_PIXELS);
    localparam int COUNT_BITS = ADDR_BITS + 1;
    localparam int SKIP_BITS  = 2;

    // ==========================================================
    // Shared types
    // ==========================================================
    typedef logic [WORD_BITS-1:0] pixel_word_t;

    // One store write, en is a single-cycle strobe
    typedef struct packed {
        logic                 en;
        logic [ADDR_BITS-1:0] addr;
        pixel_word_t          data;
    } pixel_wr_t;

    typedef struct packed {
        logic [COUNT_BITS-1:0] pixel_count;
        logic [STAT_BITS-1:0]  highlight_count;
        logic [STAT_BITS-1:0]  shadow_count;
    } capture_stats_t;

    // First header word sits in the top bits
    typedef struct packed {
        pixel_word_t [HEADER_WORDS-1:0] words;
    } header_t;

endpackage

// ==== pixel_store.sv ====
`timescale 1ns/1ns

module pixel_store import img_pkg::*; (
    input  logic                 clk,
    input  pixel_wr_t            pix_wr,
    input  logic [ADDR_BITS-1:0] rd_addr,
    output pixel_word_t          rd_data
);

    // One captured frame
    pixel_word_t mem [IMG_PIXELS];

    // Write port, fed by the capture side
    always_ff @(posedge clk) begin
        if (pix_wr.en) begin
            mem[pix_wr.addr] <= pix_wr.data;
        end
    end

    // Read port, registered, address sampled every cycle
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== readout_sequencer.sv ====
`timescale 1ns/1ns

module readout_sequencer import img_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cmd_readout,
    input  header_t              cmd_header,
    output logic [ADDR_BITS-1:0] rd_addr,
    input  pixel_word_t          rd_data,
    output logic                 readout_start,
    output logic                 readout_ready,
    input  logic                 readout_trigger,
    output pixel_word_t          readout_data
);

    enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_HEADER,
        ST_PIXEL,
        ST_TRAILER_LOAD,
        ST_TRAILER
    } state;

    logic                   readout_prev;
    logic                   readout_cmd;
    header_t                hdr_shift;
    logic [COUNT_BITS-1:0]  word_left;
    logic [ADDR_BITS-1:0]   next_addr;
    logic                   pending;
    logic                   can_load;
    logic                   xfer;
    logic                   cks_clear;
    logic                   cks_en;
    pixel_word_t            cks_din;
    logic [2*WORD_BITS-1:0] cks_sum;
    pixel_word_t            trailer_word;

    assign readout_cmd = cmd_readout ^ readout_prev;

    // Hold register may take a new word when empty or draining
    assign can_load = !readout_ready || readout_trigger;
    assign xfer     = readout_ready && readout_trigger;

    // Re-read the pending address while the hold register is blocked
    assign rd_addr = can_load ? next_addr : next_addr - ADDR_BITS'(1);

    // ==========================================================
    // Checksum over header and pixel words, host byte order
    // ==========================================================
    assign cks_clear = (state == ST_START);
    assign cks_en    = xfer && (state != ST_TRAILER);
    assign cks_din   = {readout_data[7:0], readout_data[15:8]};

    fletcher_checksum fletcher_i (
        .clk   (clk),
        .rst   (rst),
        .clear (cks_clear),
        .en    (cks_en),
        .din   (cks_din),
        .sum   (cks_sum)
    );

    // Trailer words, little endian checksum then zeros
    always_comb begin
        trailer_word = '0;
        if (word_left == COUNT_BITS'(CHECKSUM_WORDS + PADDING_WORDS)) begin
            trailer_word = {cks_sum[7:0], cks_sum[15:8]};
        end else if (word_left == COUNT_BITS'(CHECKSUM_WORDS + PADDING_WORDS - 1)) begin
            trailer_word = {cks_sum[23:16], cks_sum[31:24]};
        end
    end

    // ==========================================================
    // Readout FSM
    // ==========================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= ST_IDLE;
            readout_prev  <= 1'b0;
            readout_start <= 1'b0;
            readout_ready <= 1'b0;
            word_left     <= '0;
            next_addr     <= '0;
            pending       <= 1'b0;
        end else begin
            readout_prev <= cmd_readout;

            case (state)
                ST_START: begin
                    hdr_shift     <= cmd_header;
                    word_left     <= COUNT_BITS'(HEADER_WORDS);
                    next_addr     <= '0;
                    pending       <= 1'b0;
                    readout_ready <= 1'b0;
                    readout_start <= !readout_start;
                    state         <= ST_HEADER;
                end
                ST_HEADER: begin
                    if (can_load) begin
                        if (word_left != '0) begin
                            readout_data  <= hdr_shift.words[HEADER_WORDS-1];
                            hdr_shift     <= header_t'(hdr_shift << WORD_BITS);
                            readout_ready <= 1'b1;
                            word_left     <= word_left - 1'b1;
                        end else begin
                            readout_ready <= 1'b0;
                            word_left     <= COUNT_BITS'(IMG_PIXELS);
                            state         <= ST_PIXEL;
                        end
                    end
                end
                ST_PIXEL: begin
                    if (can_load) begin
                        // Word issued last time is in rd_data now
                        readout_ready <= pending;
                        if (pending) begin
                            readout_data <= rd_data;
                        end
                        if (word_left != '0) begin
                            pending   <= 1'b1;
                            next_addr <= next_addr + 1'b1;
                            word_left <= word_left - 1'b1;
                        end else begin
                            pending <= 1'b0;
                            state   <= ST_TRAILER_LOAD;
                        end
                    end
                end
                ST_TRAILER_LOAD: begin
                    // Sum is final once the last pixel has left
                    if (can_load) begin
                        readout_ready <= 1'b0;
                        word_left     <= COUNT_BITS'(CHECKSUM_WORDS + PADDING_WORDS);
                        state         <= ST_TRAILER;
                    end
                end
                ST_TRAILER: begin
                    if (can_load) begin
                        if (word_left != '0) begin
                            readout_data  <= trailer_word;
                            readout_ready <= 1'b1;
                            word_left     <= word_left - 1'b1;
                        end else begin
                            readout_ready <= 1'b0;
                            state         <= ST_IDLE;
                        end
                    end
                end
                default: begin
                end
            endcase

            if (readout_cmd) begin
                state <= ST_START;
            end
        end
    end

    // A word offered to the consumer stays put until taken
    assert property (@(posedge clk) disable iff (rst)
        readout_ready && !readout_trigger |=> $stable(readout_data));

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_img_controller -f all.f
./obj_dir/Vtb_img_controller | tee sim.log

if grep -q "Testbench failed" sim.log; then
    exit 1
fi
grep -q "Testbench passed" sim.log

// ==== tb_img_controller.sv ====
`timescale 1ns/1ns

module tb_img_controller import img_pkg::*; ();

    localparam int CLK_PERIOD    = 8;
    localparam int LINE_GAP      = 3;
    localparam int STREAM_WORDS  = HEADER_WORDS + IMG_PIXELS + CHECKSUM_WORDS + PADDING_WORDS;
    localparam int FRAME_CYCLES  = 8 + IMG_HEIGHT * (IMG_WIDTH + LINE_GAP) + 24;
    localparam int STREAM_CYCLES = 2 * STREAM_WORDS + 8;
    // Five frames and three readouts with slack for back-pressure
    localparam int WATCHDOG_NS   = (5 * FRAME_CYCLES + 3 * STREAM_CYCLES) * 4 * CLK_PERIOD + 1000;
    localparam header_t HDR_A    = header_t'(64'h1a2b_0008_0008_000c);
    localparam header_t HDR_B    = header_t'(64'hc3d4_0008_0008_0001);

    logic                  clk;
    logic                  rst;
    logic                  cmd_capture;
    logic                  cmd_readout;
    logic [SKIP_BITS-1:0]  cmd_skip_count;
    header_t               cmd_header;
    logic [PIXEL_BITS-1:0] img_pixel;
    logic                  img_fv;
    logic                  img_lv;
    logic                  status_capture_done;
    capture_stats_t        status_stats;
    logic                  readout_start;
    logic                  readout_ready;
    logic                  readout_trigger;
    pixel_word_t           readout_data;

    int                    errors;
    logic [PIXEL_BITS-1:0] frame_pix [IMG_PIXELS];
    logic [PIXEL_BITS-1:0] saved_pix [IMG_PIXELS];
    pixel_word_t           exp_words[$];
    pixel_word_t           ref_words[$];
    pixel_word_t           got_words[$];

    img_controller img_controller_i (
        .clk                 (clk),
        .rst                 (rst),
        .cmd_capture         (cmd_capture),
        .cmd_readout         (cmd_readout),
        .cmd_skip_count      (cmd_skip_count),
        .cmd_header          (cmd_header),
        .img_pixel           (img_pixel),
        .img_fv              (img_fv),
        .img_lv              (img_lv),
        .status_capture_done (status_capture_done),
        .status_stats        (status_stats),
        .readout_start       (readout_start),
        .readout_ready       (readout_ready),
        .readout_trigger     (readout_trigger),
        .readout_data        (readout_data)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = !clk;

    // ============================================================
    // Sensor model and reference model
    // ============================================================
    task automatic send_frame();
        @(negedge clk);
        img_fv = 1'b1;
        repeat (4) @(negedge clk);
        for (int y = 0; y < IMG_HEIGHT; y++) begin
            for (int x = 0; x < IMG_WIDTH; x++) begin
                img_lv    = 1'b1;
                img_pixel = frame_pix[y * IMG_WIDTH + x];
                @(negedge clk);
            end
            img_lv = 1'b0;
            repeat (LINE_GAP) @(negedge clk);
        end
        img_fv = 1'b0;
    endtask

    // Header, byte-swapped pixels, Fletcher-32 trailer, zero padding
    task automatic build_expected(input header_t hdr);
        int          a;
        int          b;
        pixel_word_t host;
        exp_words.delete();
        for (int i = 0; i < HEADER_WORDS; i++) begin
            exp_words.push_back(hdr.words[HEADER_WORDS-1-i]);
        end
        for (int i = 0; i < IMG_PIXELS; i++) begin
            exp_words.push_back({frame_pix[i][7:0], 4'b0000, frame_pix[i][11:8]});
        end
        a = 0;
        b = 0;
        foreach (exp_words[i]) begin
            host = {exp_words[i][7:0], exp_words[i][15:8]};
            a    = (a + int'(host)) % 65535;
            b    = (b + a) % 65535;
        end
        exp_words.push_back({a[7:0], a[15:8]});
        exp_words.push_back({b[7:0], b[15:8]});
        repeat (PADDING_WORDS) exp_words.push_back('0);
    endtask

    // ============================================================
    // Capture and readout drivers
    // ============================================================
    task automatic capture(input string name, input logic [SKIP_BITS-1:0] skip);
        logic done_before;
        int   cycles;
        done_before = status_capture_done;
        @(negedge clk);
        cmd_skip_count = skip;
        cmd_capture    = !cmd_capture;
        repeat (4) @(negedge clk);
        // Skipped frames carry inverted data so a wrong pick shows up
        for (int k = 0; k <= int'(skip); k++) begin
            if (k < int'(skip)) begin
                foreach (frame_pix[i]) frame_pix[i] = ~frame_pix[i];
            end else if (k > 0) begin
                foreach (frame_pix[i]) frame_pix[i] = ~frame_pix[i];
            end
            send_frame();
            repeat (4) @(negedge clk);
        end
        cycles = 0;
        while (status_capture_done === done_before && cycles < FRAME_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        repeat (8) @(negedge clk);
        if (status_capture_done !== !done_before) begin
            $display("FAILED %s: capture done expected %b, actual %b",
                     name, !done_before, status_capture_done);
            errors++;
        end
        if (status_stats.pixel_count !== COUNT_BITS'(IMG_PIXELS)) begin
            $display("FAILED %s: pixel count expected %0d, actual %0d",
                     name, IMG_PIXELS, status_stats.pixel_count);
            errors++;
        end
    endtask

    task automatic run_readout(input string name, input bit random_trigger);
        logic        start_before;
        logic        held;
        pixel_word_t held_data;
        int          cycles;
        got_words.delete();
        start_before = readout_start;
        held         = 1'b0;
        held_data    = '0;
        cycles       = 0;
        @(negedge clk);
        cmd_readout = !cmd_readout;
        while (got_words.size() < STREAM_WORDS && cycles < 4 * STREAM_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (held && (!readout_ready || readout_data !== held_data)) begin
                $display("%s: a waiting word changed before the consumer took it", name);
                errors++;
            end
            readout_trigger = !random_trigger || ($urandom % 2 == 1);
            if (readout_ready && readout_trigger) begin
                got_words.push_back(readout_data);
            end
            held      = readout_ready && !readout_trigger;
            held_data = readout_data;
        end
        // Last accepted word leaves on the next rising edge
        @(negedge clk);
        readout_trigger = 1'b0;
        repeat (4) @(negedge clk);
        if (got_words.size() != STREAM_WORDS) begin
            $display("%s: stream stopped after %0d of %0d words",
                     name, got_words.size(), STREAM_WORDS);
            errors++;
        end
        if (readout_start === start_before) begin
            $display("%s: readout start did not toggle", name);
            errors++;
        end
        if (readout_ready !== 1'b0) begin
            $display("FAILED %s: ready after stream expected 0, actual %b", name, readout_ready);
            errors++;
        end
        foreach (exp_words[i]) begin
            if (i < got_words.size() && got_words[i] !== exp_words[i]) begin
                $display("FAILED %s: word %0d expected %h, actual %h",
                         name, i, exp_words[i], got_words[i]);
                errors++;
            end
        end
    endtask

    // ============================================================
    // Directed tests
    // ============================================================
    task automatic check_reset_state();
        repeat (10) begin
            @(negedge clk);
            if ({readout_ready, status_capture_done, readout_start} !== 3'b000) begin
                $display("FAILED reset_state: ready/done/start expected 000, actual %b",
                         {readout_ready, status_capture_done, readout_start});
                errors++;
            end
        end
    endtask

    task automatic capture_and_readout();
        foreach (frame_pix[i]) frame_pix[i] = PIXEL_BITS'($urandom);
        saved_pix = frame_pix;
        capture("capture_readout", 2'd0);
        cmd_header = HDR_A;
        build_expected(HDR_A);
        ref_words = exp_words;
        run_readout("capture_readout", 1'b0);
    endtask

    task automatic skip_one_frame();
        foreach (frame_pix[i]) frame_pix[i] = PIXEL_BITS'($urandom);
        capture("skip_frame", 2'd1);
        cmd_header = HDR_B;
        build_expected(HDR_B);
        run_readout("skip_frame", 1'b0);
    endtask

    task automatic check_statistics();
        int highlights;
        int shadows;
        foreach (frame_pix[i]) frame_pix[i] = PIXEL_BITS'(12'h200 + $urandom % 12'ha00);
        // Counted block corners then extremes at uncounted spots
        frame_pix[0]  = 12'hfff;
        frame_pix[4]  = 12'h01f;
        frame_pix[32] = 12'hfe0;
        frame_pix[36] = 12'h800;
        frame_pix[9]  = 12'hfff;
        frame_pix[2]  = 12'h000;
        frame_pix[35] = 12'h000;
        frame_pix[16] = 12'hff0;
        highlights = 0;
        shadows    = 0;
        foreach (frame_pix[i]) begin
            if ((i % IMG_WIDTH) % 4 == 0 && (i / IMG_WIDTH) % 4 == 0) begin
                if (frame_pix[i][11:5] == 7'h7f) highlights++;
                if (frame_pix[i][11:5] == 7'h00) shadows++;
            end
        end
        capture("statistics", 2'd0);
        if (status_stats.highlight_count !== STAT_BITS'(highlights)) begin
            $display("FAILED statistics: highlights expected %0d, actual %0d",
                     highlights, status_stats.highlight_count);
            errors++;
        end
        if (status_stats.shadow_count !== STAT_BITS'(shadows)) begin
            $display("FAILED statistics: shadows expected %0d, actual %0d",
                     shadows, status_stats.shadow_count);
            errors++;
        end
    endtask

    task automatic readout_back_pressure();
        frame_pix = saved_pix;
        capture("back_pressure", 2'd0);
        cmd_header = HDR_A;
        exp_words  = ref_words;
        run_readout("back_pressure", 1'b1);
    endtask

    initial begin
        void'($urandom(40));
        errors          = 0;
        rst             = 1'b1;
        cmd_capture     = 1'b0;
        cmd_readout     = 1'b0;
        cmd_skip_count  = '0;
        cmd_header      = '0;
        img_pixel       = '0;
        img_fv          = 1'b0;
        img_lv          = 1'b0;
        readout_trigger = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        check_reset_state();
        capture_and_readout();
        skip_one_frame();
        check_statistics();
        readout_back_pressure();

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests completed");
        $display("Testbench failed");
        $finish;
    end

endmodule
